/* Makefile */
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/1ns -f vlog.f --top-module ramBlockTb
	@out=$$(./obj_dir/VramBlockTb +verilator+error+limit+100); \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

/* bench/hyperRamModel.sv */
// behavioral x8 HyperRAM, one word per access; odd word addresses answer a cycle late, no timing checks
`timescale 1ns/1ns
`include "ramBlock_consts.svh"
`default_nettype none

module hyperRamModel
	import ramPkg::*;
(
	input  wire                      sClk,
	input  wire hyperPins            pins,
	output logic [`RAM_DQ_WIDTH-1:0] dqIn,
	output logic                     rwdsIn
);

	// first data beat after the command-address and the latency
	localparam int DATA_BEAT = `CA_BYTES + `RAM_LATENCY;

	logic [`RAM_WORD_WIDTH-1:0] mem [logic [`RAM_ADRS_WIDTH-1:0]];
	logic [`CA_BYTES*`RAM_DQ_WIDTH-1:0] ca = '0;
	logic [`RAM_ADRS_WIDTH-1:0] adrs;
	logic [`RAM_DQ_WIDTH-1:0] hiByte;
	logic [`RAM_WORD_WIDTH-1:0] rdWord = '0;
	logic isRead;
	int beat = 0;
	int firstBeat;

	// decode of the captured command-address
	assign isRead = ca[47];
	assign adrs   = {ca[44:16], ca[2:0]};
	// odd address, one extra wait cycle before the strobe
	assign firstBeat = DATA_BEAT + int'(adrs[0]);

	// read answer, strobe high for each valid byte
	assign rwdsIn = !pins.csN && isRead && (beat == firstBeat || beat == firstBeat + 1);
	assign dqIn   = (beat == firstBeat) ? rdWord[15:8] : rdWord[7:0];

	always @(posedge sClk)
	begin
		if (pins.csN)
			beat <= 0;
		else
		begin
			beat <= beat + 1;
			// CA bytes arrive MSB first
			if (beat < `CA_BYTES)
				ca <= {ca[39:0], pins.dq};
			// look up the word once the address is complete
			if (beat == `CA_BYTES)
				rdWord <= mem.exists(adrs) ? mem[adrs] : (adrs[15:0] ^ adrs[31:16]);
			if (!isRead && beat == DATA_BEAT)
				hiByte <= pins.dq;
			// store on the low byte
			if (!isRead && beat == DATA_BEAT + 1)
				mem[adrs] = {hiByte, pins.dq};
		end
	end

endmodule

`default_nettype wire

/* bench/ramBlockTb.sv */
// runs about 18 single-word transactions; the model answers reads, the bound checker guards the pins
`timescale 1ns/1ns
`include "ramBlock_consts.svh"
`default_nettype none

module ramBlockTb
	import ramPkg::*;
();

	localparam int CA_W = `CA_BYTES * `RAM_DQ_WIDTH;
	// csN low for CA, latency and two data bytes
	localparam int BUS_CYCLES = `CA_BYTES + `RAM_LATENCY + 2;
	// one extra cycle for the registered start pulse
	localparam int WRITE_CYCLES = BUS_CYCLES + 1;
	localparam int WATCH_NS = 40 * 30 * 4;

	logic sClk = 1'b0;
	logic arstN;
	csrReq csr;
	logic [`RAM_WORD_WIDTH-1:0] csrRData;
	hyperPins pins;
	logic [`RAM_DQ_WIDTH-1:0] dqIn;
	logic rwdsIn;

	int seed;
	int cycleCount = 0;
	int xferCount = 0;
	logic lastCsN = 1'b1;
	logic [`RAM_DQ_WIDTH-1:0] busBytes [$];
	// dqOe, rwdsOe, rwds and ck of every cycle under chip select
	logic [3:0] busCtl [$];
	// scoreboard of written words
	logic [`RAM_ADRS_WIDTH-1:0] sbAdrs [8];
	logic [`RAM_WORD_WIDTH-1:0] sbData [8];

	always #2 sClk = ~sClk;

	ramBlock dut0
	(
		.sClk     (sClk),
		.arstN    (arstN),
		.csr      (csr),
		.csrRData (csrRData),
		.pins     (pins),
		.dqIn     (dqIn),
		.rwdsIn   (rwdsIn)
	);

	hyperRamModel mem0
	(
		.sClk   (sClk),
		.pins   (pins),
		.dqIn   (dqIn),
		.rwdsIn (rwdsIn)
	);

	bind ramBlock ramBlock_assert chk0
	(
		.sClk   (sClk),
		.arstN  (arstN),
		.pins   (pins),
		.rwdsIn (rwdsIn),
		.start  (start),
		.busy   (busy),
		.done   (done)
	);

	always @(posedge sClk)
		cycleCount <= cycleCount + 1;

	// bus monitor, dq and controls of every cycle under chip select
	always @(negedge sClk)
	begin
		if (!pins.csN)
		begin
			busBytes.push_back(pins.dq);
			busCtl.push_back({pins.dqOe, pins.rwdsOe, pins.rwds, pins.ck});
		end
		if (!pins.csN && lastCsN)
			xferCount <= xferCount + 1;
		lastCsN <= pins.csN;
		// complement clock at all times
		expectEq("pins.ckN", int'(pins.ckN), int'(!pins.ck));
	end

	// ------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------
	task automatic abortRun(input string why);
		$display("%s", why);
		$display("TEST RESULT: FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic expectEq(input string name, input int got, input int exp);
		assert (got == exp)
		else
			abortRun($sformatf("Mismatch at %0t ns: %s expected 0x%0h, got 0x%0h",
				$time, name, exp, got));
	endtask

	// read flag, memory space, linear burst, upper address, reserved, low address
	function automatic logic [CA_W-1:0] caExpected(input ramOp op, input logic [31:0] a);
		caExpected = {op == opRead, 1'b0, 1'b1, a[31:3], 13'd0, a[2:0]};
	endfunction

	task automatic writeCsr(input logic [3:0] a, input logic [15:0] d);
		@(negedge sClk);
		csr.adrs = a;
		csr.wData = d;
		csr.we = 1'b1;
		@(negedge sClk);
		csr.we = 1'b0;
	endtask

	task automatic readCsr(input logic [3:0] a, output logic [15:0] d);
		@(negedge sClk);
		csr.adrs = a;
		csr.we = 1'b0;
		#1;
		d = csrRData;
	endtask

	// poll status until done, busy must mirror csN
	task automatic waitDone(input int startCycle, output int elapsed);
		logic [15:0] st;
		st = '0;
		while (!st[0])
		begin
			readCsr(`CSR_STATUS, st);
			expectEq("status busy vs !pins.csN", int'(st[1]), int'(!pins.csN));
		end
		elapsed = cycleCount - startCycle;
	endtask

	task automatic runXfer(input ramOp op, input logic [31:0] a, input logic [15:0] d);
		int startCycle;
		int elapsed;
		logic [CA_W-1:0] ca;
		ca = caExpected(op, a);
		writeCsr(`CSR_ADRS_LO, a[15:0]);
		writeCsr(`CSR_ADRS_HI, a[31:16]);
		writeCsr(`CSR_WDATA, d);
		writeCsr(`CSR_STATUS, '0);
		busBytes.delete();
		busCtl.delete();
		writeCsr(`CSR_CTRL, {14'd0, op == opRead, 1'b1});
		startCycle = cycleCount;
		waitDone(startCycle, elapsed);
		for (int k = 0; k < `CA_BYTES; k++)
			expectEq("pins.dq CA byte", int'(busBytes[k]), int'(ca[CA_W-1-8*k -: 8]));
		// ck toggles from low, rwds only driven for write data, dqOe off for read data
		for (int k = 0; k < busCtl.size(); k++)
		begin
			expectEq("pins.ck", int'(busCtl[k][0]), k % 2);
			expectEq("pins.rwds", int'(busCtl[k][1]), 0);
			expectEq("pins.rwdsOe", int'(busCtl[k][2]),
				(op == opWrite && k >= BUS_CYCLES - 2) ? 1 : 0);
			expectEq("pins.dqOe", int'(busCtl[k][3]),
				(op == opWrite || k < BUS_CYCLES - 2) ? 1 : 0);
		end
		if (op == opWrite)
		begin
			expectEq("cycles from start to done", elapsed, WRITE_CYCLES);
			expectEq("cycles with csN low", busBytes.size(), BUS_CYCLES);
			expectEq("pins.dq write high byte", int'(busBytes[BUS_CYCLES-2]), int'(d[15:8]));
			expectEq("pins.dq write low byte", int'(busBytes[BUS_CYCLES-1]), int'(d[7:0]));
		end
	endtask

	// ------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------
	initial
	begin
		logic [15:0] rd;
		int startCycle;
		int elapsed;
		int startCount;
		seed = 32'hcbe0;
		csr = '0;
		arstN = 1'b0;
		repeat (2) @(negedge sClk);
		expectEq("pins.rstN during reset", int'(pins.rstN), 0);
		arstN = 1'b1;

		// idle pins and cleared registers after reset
		@(negedge sClk);
		#1;
		expectEq("pins.csN", int'(pins.csN), 1);
		expectEq("pins.dqOe", int'(pins.dqOe), 0);
		expectEq("pins.rwdsOe", int'(pins.rwdsOe), 0);
		expectEq("pins.ck", int'(pins.ck), 0);
		expectEq("pins.rstN", int'(pins.rstN), 1);
		for (int r = int'(`CSR_CTRL); r <= int'(`CSR_RDATA); r++)
		begin
			readCsr(4'(r), rd);
			expectEq("csrRData after reset", int'(rd), 0);
		end

		// distinct low bits keep the addresses apart
		for (int i = 0; i < 8; i++)
		begin
			sbAdrs[i] = {29'($random(seed)), 3'(i)};
			sbData[i] = 16'($random(seed));
			runXfer(opWrite, sbAdrs[i], sbData[i]);
		end
		for (int i = 7; i >= 0; i--)
		begin
			runXfer(opRead, sbAdrs[i], 16'd0);
			readCsr(`CSR_RDATA, rd);
			expectEq("csrRData read word", int'(rd), int'(sbData[i]));
		end

		// second start lands mid-transaction and is dropped
		sbData[0] = 16'($random(seed));
		writeCsr(`CSR_WDATA, sbData[0]);
		writeCsr(`CSR_STATUS, '0);
		startCount = xferCount;
		writeCsr(`CSR_CTRL, 16'h0001);
		startCycle = cycleCount;
		repeat (3) @(negedge sClk);
		writeCsr(`CSR_CTRL, 16'h0001);
		waitDone(startCycle, elapsed);
		expectEq("cycles from start to done", elapsed, WRITE_CYCLES);
		readCsr(`CSR_STATUS, rd);
		expectEq("status after dropped start", int'(rd), 5);
		expectEq("transactions for two starts", xferCount - startCount, 1);

		// status write clears done and drop
		writeCsr(`CSR_STATUS, '0);
		readCsr(`CSR_STATUS, rd);
		expectEq("status after clear", int'(rd), 0);
		runXfer(opRead, sbAdrs[0], 16'd0);
		readCsr(`CSR_RDATA, rd);
		expectEq("csrRData read word", int'(rd), int'(sbData[0]));

		repeat (2) @(negedge sClk);
		if (dut0.chk0.anyFail)
			abortRun("a pin protocol assertion failed");
		else
		begin
			$display("TEST RESULT: PASS");
			$finish;
		end
	end

	// assertion failures end the run at once
	initial
	begin
		wait (dut0.chk0.anyFail);
		abortRun("a pin protocol assertion failed");
	end

	initial
	begin
		#(WATCH_NS);
		abortRun("timeout, transactions did not complete in time");
	end

endmodule

`default_nettype wire

/* bench/ramBlock_assert.sv */
// pin protocol checks for ramBlock; each failing assertion also raises a flag seen through anyFail
`timescale 1ns/1ns
`default_nettype none

module ramBlock_assert
	import ramPkg::*;
(
	input wire           sClk,
	input wire           arstN,
	input wire hyperPins pins,
	input wire           rwdsIn,
	input wire           start,
	input wire           busy,
	input wire           done
);

	logic ckErr = 1'b0;
	logic turnErr = 1'b0;
	logic doneErr = 1'b0;
	logic startErr = 1'b0;
	logic anyFail;

	assign anyFail = ckErr | turnErr | doneErr | startErr;

	// ------------------------------------------------------------
	// memory clock
	// ------------------------------------------------------------
	ckHold: assert property (@(posedge sClk) disable iff (!arstN)
		$past(pins.csN) && pins.csN |-> !pins.ck && $stable(pins.ck) && pins.ckN)
	else
	begin
		ckErr = 1'b1;
		$error("memory clock moved while csN was high");
	end

	// controller off dq while the memory strobes read data
	readTurn: assert property (@(posedge sClk) disable iff (!arstN)
		rwdsIn |-> !pins.dqOe)
	else
	begin
		turnErr = 1'b1;
		$error("dqOe high during read data");
	end

	// ------------------------------------------------------------
	// command handoff
	// ------------------------------------------------------------
	doneIdle: assert property (@(posedge sClk) disable iff (!arstN)
		done |-> !busy)
	else
	begin
		doneErr = 1'b1;
		$error("done high while busy");
	end

	startTaken: assert property (@(posedge sClk) disable iff (!arstN)
		start && !busy && !done |=> busy)
	else
	begin
		startErr = 1'b1;
		$error("start in idle did not open a transaction");
	end

endmodule

`default_nettype wire

/* verilog/hyperRamSequencer.sv */
// one byte per sClk, ck toggles every cycle; no double latency, a read without RWDS waits forever
`timescale 1ns/1ns
`include "ramBlock_consts.svh"
`default_nettype none

module hyperRamSequencer
	import ramPkg::*;
(
	input  wire                        sClk,
	input  wire                        arstN,
	input  wire ramCmd                 cmd,
	input  wire                        start,
	output logic                       busy,
	output logic                       done,
	output logic [`RAM_WORD_WIDTH-1:0] capData,
	output hyperPins                   pins,
	input  wire [`RAM_DQ_WIDTH-1:0]    dqIn,
	input  wire                        rwdsIn
);

	localparam int CA_WIDTH = `CA_BYTES * `RAM_DQ_WIDTH;
	// reserved CA bits 15..3
	localparam int RSV_BITS = 13;

	seqState state;
	logic [2:0] cnt;
	ramOp xferOp;

	logic [CA_WIDTH-1:0] caWord;
	logic [CA_WIDTH-1:0] caShift;
	logic [`RAM_WORD_WIDTH-1:0] wordReg;

	// registered pin state
	logic [`RAM_DQ_WIDTH-1:0] dqReg;
	logic dqOe;
	logic rwdsOe;
	logic ck;
	logic csN;

	logic closing;

	// ------------------------------------------------------------
	// command-address, read flag / memory space / linear burst
	// ------------------------------------------------------------
	assign caWord = {cmd.op == opRead, 1'b0, 1'b1,
		cmd.adrs[`RAM_ADRS_WIDTH-1:3], RSV_BITS'(0), cmd.adrs[2:0]};

	// last data cycle
	// writes close on the second byte, reads on the second strobed byte
	assign closing = (state == stData) && (cnt == 3'd1) &&
		((xferOp == opWrite) || rwdsIn);

	always_ff @(posedge sClk or negedge arstN)
	begin
		if (!arstN)
		begin
			state  <= stIdle;
			cnt    <= '0;
			xferOp <= opWrite;
			dqReg  <= '0;
			dqOe   <= 1'b0;
			rwdsOe <= 1'b0;
			ck     <= 1'b0;
			csN    <= 1'b1;
			done   <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			// toggle only under chip select, park low when it closes
			ck <= (csN || closing) ? 1'b0 : ~ck;

			case (state)
				stIdle:
				begin
					if (start)
					begin
						state  <= stCmd;
						cnt    <= '0;
						xferOp <= cmd.op;
						csN    <= 1'b0;
						dqOe   <= 1'b1;
						dqReg  <= caWord[CA_WIDTH-1 -: `RAM_DQ_WIDTH];
					end
				end

				// six CA bytes, MSB first
				stCmd:
				begin
					if (cnt == 3'(`CA_BYTES - 1))
					begin
						state <= stLatency;
						cnt   <= '0;
						dqReg <= '0;
					end
					else
					begin
						cnt   <= cnt + 3'd1;
						dqReg <= caShift[CA_WIDTH-1 -: `RAM_DQ_WIDTH];
					end
				end

				stLatency:
				begin
					if (cnt == 3'(`RAM_LATENCY - 1))
					begin
						state <= stData;
						cnt   <= '0;
						if (xferOp == opWrite)
						begin
							// high byte first, rwds low means no mask
							dqReg  <= wordReg[`RAM_WORD_WIDTH-1 -: `RAM_DQ_WIDTH];
							rwdsOe <= 1'b1;
						end
						else
							dqOe <= 1'b0;
					end
					else
						cnt <= cnt + 3'd1;
				end

				stData:
				begin
					if (closing)
					begin
						state  <= stDone;
						cnt    <= '0;
						csN    <= 1'b1;
						dqOe   <= 1'b0;
						rwdsOe <= 1'b0;
						done   <= 1'b1;
					end
					else if (xferOp == opWrite)
					begin
						cnt   <= cnt + 3'd1;
						dqReg <= wordReg[`RAM_DQ_WIDTH-1:0];
					end
					// read waits here for the strobe
					else if (rwdsIn)
						cnt <= cnt + 3'd1;
				end

				// one idle cycle with done high
				stDone:
					state <= stIdle;

				default:
					state <= stIdle;
			endcase
		end
	end

	// ------------------------------------------------------------
	// payload shift registers
	// ------------------------------------------------------------
	always_ff @(posedge sClk)
	begin
		if ((state == stIdle) && start)
		begin
			caShift <= caWord << `RAM_DQ_WIDTH;
			wordReg <= cmd.wData;
		end
		else if (state == stCmd)
			caShift <= caShift << `RAM_DQ_WIDTH;
		else if ((state == stData) && (xferOp == opRead) && rwdsIn)
			wordReg <= {wordReg[`RAM_DQ_WIDTH-1:0], dqIn};
	end

	// valid for reads when done pulses
	assign capData = wordReg;
	assign busy    = ~csN;

	assign pins.dq     = dqReg;
	assign pins.dqOe   = dqOe;
	assign pins.rwds   = 1'b0;
	assign pins.rwdsOe = rwdsOe;
	assign pins.ck     = ck;
	assign pins.ckN    = ~ck;
	assign pins.csN    = csN;
	// memory reset follows the block reset
	assign pins.rstN   = arstN;

endmodule

`default_nettype wire

/* verilog/ramBlock.sv */
// dq and rwds are split into in and out with enables; tristate buffers live outside this block
`timescale 1ns/1ns
`include "ramBlock_consts.svh"
`default_nettype none

module ramBlock
	import ramPkg::*;
(
	input  wire                        sClk,
	input  wire                        arstN,
	input  wire csrReq                 csr,
	output logic [`RAM_WORD_WIDTH-1:0] csrRData,
	output hyperPins                   pins,
	input  wire [`RAM_DQ_WIDTH-1:0]    dqIn,
	input  wire                        rwdsIn
);

	// ------------------------------------------------------------
	// register file to sequencer
	// ------------------------------------------------------------
	ramCmd cmd;
	logic start;
	logic busy;
	logic done;
	logic [`RAM_WORD_WIDTH-1:0] capData;

	ramCsr csr0
	(
		.sClk     (sClk),
		.arstN    (arstN),
		.csr      (csr),
		.csrRData (csrRData),
		.cmd      (cmd),
		.start    (start),
		.busy     (busy),
		.done     (done),
		.capData  (capData)
	);

	// HyperBus pin side
	hyperRamSequencer seq0
	(
		.sClk    (sClk),
		.arstN   (arstN),
		.cmd     (cmd),
		.start   (start),
		.busy    (busy),
		.done    (done),
		.capData (capData),
		.pins    (pins),
		.dqIn    (dqIn),
		.rwdsIn  (rwdsIn)
	);

endmodule

`default_nettype wire

/* verilog/ramBlock_consts.svh */
// fixed for an x8 HyperRAM, one 16-bit word per access, single initial latency only
`ifndef RAMBLOCK_CONSTS_SVH
`define RAMBLOCK_CONSTS_SVH
`default_nettype none

// ------------------------------------------------------------
// pin and word widths
// ------------------------------------------------------------
`define RAM_DQ_WIDTH	8
`define RAM_WORD_WIDTH	16
`define RAM_ADRS_WIDTH	32
`define CSR_ADRS_WIDTH	4

// cycles between last command-address byte and first data byte
`define RAM_LATENCY	6
// 48-bit command-address in bytes
`define CA_BYTES	6

// ------------------------------------------------------------
// register map
// ------------------------------------------------------------
`define CSR_CTRL	4'd0
`define CSR_STATUS	4'd1
`define CSR_ADRS_LO	4'd2
`define CSR_ADRS_HI	4'd3
`define CSR_WDATA	4'd4
`define CSR_RDATA	4'd5

`default_nettype wire
`endif

/* verilog/ramCsr.sv */
// single-word commands only; a start while busy or finishing is dropped and flagged in status bit 2
`timescale 1ns/1ns
`include "ramBlock_consts.svh"
`default_nettype none

module ramCsr
	import ramPkg::*;
(
	input  wire                        sClk,
	input  wire                        arstN,
	input  wire csrReq                 csr,
	output logic [`RAM_WORD_WIDTH-1:0] csrRData,
	output ramCmd                      cmd,
	output logic                       start,
	input  wire                        busy,
	input  wire                        done,
	input  wire [`RAM_WORD_WIDTH-1:0]  capData
);

	// ------------------------------------------------------------
	// register storage
	// ------------------------------------------------------------
	logic [`RAM_WORD_WIDTH-1:0] adrsLo;
	logic [`RAM_WORD_WIDTH-1:0] adrsHi;
	logic [`RAM_WORD_WIDTH-1:0] wDataReg;
	logic [`RAM_WORD_WIDTH-1:0] rDataReg;
	// op for the next start, and op of the transaction in flight
	ramOp opReg;
	ramOp xferOp;
	// sticky status flags
	logic doneBit;
	logic dropBit;

	logic ctrlWr;
	logic statusWr;
	logic accept;

	assign ctrlWr   = csr.we && (csr.adrs == `CSR_CTRL);
	assign statusWr = csr.we && (csr.adrs == `CSR_STATUS);
	// sequencer only takes start in idle, which is neither busy nor done
	assign accept   = start && !busy && !done;

	// word address split over two halves
	assign cmd.op    = opReg;
	assign cmd.adrs  = {adrsHi, adrsLo};
	assign cmd.wData = wDataReg;

	always_ff @(posedge sClk or negedge arstN)
	begin
		if (!arstN)
		begin
			adrsLo   <= '0;
			adrsHi   <= '0;
			wDataReg <= '0;
			rDataReg <= '0;
			opReg    <= opWrite;
			xferOp   <= opWrite;
			doneBit  <= 1'b0;
			dropBit  <= 1'b0;
			start    <= 1'b0;
		end
		else
		begin
			// start is a one-cycle pulse from ctrl bit 0
			start <= ctrlWr && csr.wData[0];

			if (csr.we)
			begin
				case (csr.adrs)
					`CSR_CTRL:    opReg    <= ramOp'(csr.wData[1]);
					`CSR_ADRS_LO: adrsLo   <= csr.wData;
					`CSR_ADRS_HI: adrsHi   <= csr.wData;
					`CSR_WDATA:   wDataReg <= csr.wData;
					default:      ;
				endcase
			end

			// remember direction so a later ctrl write can't confuse read-back
			if (accept)
				xferOp <= opReg;

			// completion beats a clearing write in the same cycle
			if (done)
				doneBit <= 1'b1;
			else if (statusWr)
				doneBit <= 1'b0;

			if (start && !accept)
				dropBit <= 1'b1;
			else if (statusWr)
				dropBit <= 1'b0;

			if (done && (xferOp == opRead))
				rDataReg <= capData;
		end
	end

	// ------------------------------------------------------------
	// read mux, combinational on csr.adrs
	// ------------------------------------------------------------
	always_comb
	begin
		case (csr.adrs)
			`CSR_CTRL:
				csrRData = {{(`RAM_WORD_WIDTH-2){1'b0}}, opReg == opRead, 1'b0};
			// done shows live so software sees it in the done cycle
			`CSR_STATUS:
				csrRData = {{(`RAM_WORD_WIDTH-3){1'b0}}, dropBit, busy, doneBit | done};
			`CSR_ADRS_LO: csrRData = adrsLo;
			`CSR_ADRS_HI: csrRData = adrsHi;
			`CSR_WDATA:   csrRData = wDataReg;
			`CSR_RDATA:   csrRData = rDataReg;
			default:      csrRData = '0;
		endcase
	end

endmodule

`default_nettype wire

/* verilog/ramPkg.sv */
// shared types; field widths come from the consts header and must match the RTL built with it
`include "ramBlock_consts.svh"
`default_nettype none

package ramPkg;

	// transaction direction, opRead becomes CA bit 47
	typedef enum logic
	{
		opWrite = 1'b0,
		opRead  = 1'b1
	} ramOp;

	// sequencer phases
	typedef enum logic [2:0]
	{
		stIdle,
		stCmd,
		stLatency,
		stData,
		stDone
	} seqState;

	// one register bus access, read address or write
	typedef struct packed
	{
		logic [`CSR_ADRS_WIDTH-1:0] adrs;
		logic [`RAM_WORD_WIDTH-1:0] wData;
		logic                       we;
	} csrReq;

	// command from register file to sequencer
	typedef struct packed
	{
		ramOp                       op;
		logic [`RAM_ADRS_WIDTH-1:0] adrs;
		logic [`RAM_WORD_WIDTH-1:0] wData;
	} ramCmd;

	// everything driven toward the memory
	typedef struct packed
	{
		logic [`RAM_DQ_WIDTH-1:0] dq;
		logic                     dqOe;
		logic                     rwds;
		logic                     rwdsOe;
		logic                     ck;
		logic                     ckN;
		logic                     csN;
		logic                     rstN;
	} hyperPins;

endpackage

`default_nettype wire

/* vlog.f */
+incdir+verilog
verilog/ramPkg.sv
verilog/ramCsr.sv
verilog/hyperRamSequencer.sv
verilog/ramBlock.sv
bench/hyperRamModel.sv
bench/ramBlock_assert.sv
bench/ramBlockTb.sv
